/* compile.f */
+incdir+testbench
design/tetrisPkg.sv
design/pieceIf.sv
design/keyDecode.sv
design/pieceMover.sv
design/boardRender.sv
design/tetrisCore.sv
testbench/tetrisTb.sv

/* testbench/tetrisModel.svh */
`ifndef TETRIS_MODEL_SVH
`define TETRIS_MODEL_SVH
`default_nettype none

// Live piece as the model sees it
typedef struct packed {
    logic [2:0] kind;
    logic [1:0] rot;
    logic [3:0] x;
    logic [4:0] y;
} modelPieceT;

// Move codes, same order as the key codes minus one
localparam int moveLeft   = 0;
localparam int moveRight  = 1;
localparam int moveRotate = 2;
localparam int moveDrop   = 3;

// Eight signed nibbles, column then row of each cell
function automatic logic [31:0] packCells(input int x0, input int y0, input int x1,
                                          input int y1, input int x2, input int y2,
                                          input int x3, input int y3);
    packCells = {4'(y3), 4'(x3), 4'(y2), 4'(x2), 4'(y1), 4'(x1), 4'(y0), 4'(x0)};
endfunction

function automatic logic [31:0] shapeTable(input logic [2:0] kind, input logic [1:0] rot);
    case ({kind, rot})
        5'b000_00, 5'b000_10: shapeTable = packCells(-2, 0, -1, 0, 0, 0, 1, 0);
        5'b000_01, 5'b000_11: shapeTable = packCells(0, -2, 0, -1, 0, 0, 0, 1);
        5'b010_00: shapeTable = packCells(-1, 0, 0, 0, 1, 0, 0, -1);
        5'b010_01: shapeTable = packCells(0, -1, 0, 0, 0, 1, 1, 0);
        5'b010_10: shapeTable = packCells(-1, 0, 0, 0, 1, 0, 0, 1);
        5'b010_11: shapeTable = packCells(0, -1, 0, 0, 0, 1, -1, 0);
        5'b011_00: shapeTable = packCells(-1, 0, 0, 0, 1, 0, 1, -1);
        5'b011_01: shapeTable = packCells(0, -1, 0, 0, 0, 1, 1, 1);
        5'b011_10: shapeTable = packCells(-1, 0, 0, 0, 1, 0, -1, 1);
        5'b011_11: shapeTable = packCells(0, -1, 0, 0, 0, 1, -1, -1);
        5'b100_00: shapeTable = packCells(-1, 0, 0, 0, 0, -1, 1, -1);
        5'b100_01: shapeTable = packCells(0, 0, -1, 0, -1, -1, 0, 1);
        5'b100_10: shapeTable = packCells(0, 0, 1, 0, -1, -1, 0, -1);
        5'b100_11: shapeTable = packCells(0, 0, -1, 0, 0, -1, -1, 1);
        // Square, same in every rotation
        default:   shapeTable = packCells(0, -1, 1, -1, 0, 0, 1, 0);
    endcase
endfunction

function automatic bit insideBoard(input modelPieceT p);
    logic [31:0] cells;
    int col;
    int row;
    cells = shapeTable(p.kind, p.rot);
    insideBoard = 1'b1;
    for (int i = 0; i < 4; i++) begin
        col = int'(p.x) + $signed(cells[8*i +: 4]);
        row = int'(p.y) + $signed(cells[8*i + 4 +: 4]);
        if (col < 0 || col > 9 || row < 0 || row > 23) insideBoard = 1'b0;
    end
endfunction

// Column 0 minus one wraps to 15, which still lands off the board
function automatic modelPieceT movedPiece(input modelPieceT p, input int move);
    movedPiece = p;
    case (move)
        moveLeft:   movedPiece.x = p.x - 4'd1;
        moveRight:  movedPiece.x = p.x + 4'd1;
        moveRotate: movedPiece.rot = p.rot + 2'd1;
        default:    movedPiece.y = p.y + 5'd1;
    endcase
endfunction

function automatic modelPieceT spawnPiece(input logic [2:0] kind);
    spawnPiece.kind = kind;
    spawnPiece.rot  = 2'd0;
    spawnPiece.x    = 4'd5;
    spawnPiece.y    = 5'd2;
endfunction

function automatic logic [199:0] renderPiece(input modelPieceT p);
    logic [31:0] cells;
    int col;
    int row;
    cells = shapeTable(p.kind, p.rot);
    renderPiece = '0;
    for (int i = 0; i < 4; i++) begin
        col = int'(p.x) + $signed(cells[8*i +: 4]);
        row = int'(p.y) + $signed(cells[8*i + 4 +: 4]);
        if (row >= 4 && row < 24 && col >= 0 && col < 10) renderPiece[(row - 4) * 10 + col] = 1'b1;
    end
endfunction

// Right-shifting Galois LFSR
function automatic logic [15:0] galoisStep(input logic [15:0] value);
    galoisStep = (value >> 1) ^ (value[0] ? 16'hB400 : 16'h0000);
endfunction

`default_nettype wire
`endif

/* testbench/tetrisTb.sv */
`timescale 1ns/100ps
`include "tetrisModel.svh"
`default_nettype none

module tetrisTb import tetrisPkg::*; ();

    localparam int resetCycles    = 10;
    localparam int directedCycles = 260;
    localparam int randomCycles   = 2000;
    localparam int cycleLimit     = resetCycles + directedCycles + randomCycles + 200;

    logic  clk_div;
    logic  rstReg;
    logic  keyValid;
    keyT   key;
    logic  dropTick;
    boardT objects;
    blockT nextBlock;

    // Model registers
    logic         mArmed;
    logic         mCmdValid;
    int           mCmd;
    modelPieceT   mPiece;
    logic [2:0]   mNext;
    logic [15:0]  mLfsr;
    logic [199:0] mObjects;
    int           mLandings;

    logic [15:0] randState;
    int cycleCount = 0;
    int errorCount = 0;
    int checkCount = 0;
    int testErrors = 0;
    int failedTests = 0;
    int testsRun = 0;

    tetrisCore #(.lfsrSeed(16'hACE1)) i_dut (
        .clk_div(clk_div), .rstReg(rstReg), .keyValid(keyValid), .key(key),
        .dropTick(dropTick), .objects(objects), .nextBlock(nextBlock)
    );

    initial begin
        clk_div = 1'b0;
        forever #2 clk_div = ~clk_div;
    end

    always @(posedge clk_div) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Run timed out after %0d cycles", cycleCount);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // ########################################
    // Checks, random bits and the model clock
    // ########################################
    task automatic checkValue(input string name, input logic [199:0] got,
                              input logic [199:0] expected);
        checkCount++;
        if (got !== expected) begin
            errorCount++;
            $display("FAIL at %0t: %s got %0h, expected %0h", $time, name, got, expected);
        end
    endtask

    function automatic int randBits(input int count);
        randBits = 0;
        for (int i = 0; i < count; i++) begin
            randState = galoisStep(randState);
            randBits = (randBits << 1) | randState[0];
        end
    endfunction

    // All stages advance from their old values, render first
    task automatic modelClock(input logic kv, input keyT k, input logic dt);
        logic act;
        modelPieceT cand;
        act = kv && (k != keyIdle) && mArmed;
        cand = movedPiece(mPiece, mCmd);
        mObjects = renderPiece(mPiece);
        if (mCmdValid && insideBoard(cand)) begin
            mPiece = cand;
        end else if (mCmdValid && mCmd == moveDrop) begin
            mLfsr = galoisStep(mLfsr);
            mPiece = spawnPiece(mNext);
            mNext = mLfsr % 5;
            mLandings++;
        end
        mCmdValid = dt || act;
        if (dt) mCmd = moveDrop;
        else if (act) mCmd = int'(k) - 1;
        if (kv) mArmed = (k == keyIdle);
    endtask

    task automatic step(input logic kv, input keyT k, input logic dt);
        keyValid = kv;
        key      = k;
        dropTick = dt;
        @(posedge clk_div);
        modelClock(kv, k, dt);
        #1;
        checkValue("objects", objects, mObjects);
        checkValue("nextBlock", nextBlock, mNext);
    endtask

    task automatic press(input keyT k, input int times);
        repeat (times) begin
            step(1'b1, k, 1'b0);
            step(1'b1, keyIdle, 1'b0);
        end
    endtask

    task automatic drops(input int times);
        repeat (times) step(1'b0, keyIdle, 1'b1);
    endtask

    task automatic settle();
        repeat (3) step(1'b0, keyIdle, 1'b0);
    endtask

    function automatic logic [199:0] cellBits(input int a, input int b, input int c, input int d);
        cellBits = '0;
        cellBits[a] = 1'b1;
        cellBits[b] = 1'b1;
        cellBits[c] = 1'b1;
        cellBits[d] = 1'b1;
    endfunction

    task automatic finishTest(input string name);
        testsRun++;
        if (errorCount == testErrors) begin
            $display("Test %s: ok", name);
        end else begin
            failedTests++;
            $display("Test %s: %0d errors", name, errorCount - testErrors);
        end
        testErrors = errorCount;
    endtask

    // ########################################
    // Test sequence
    // ########################################
    initial begin
        logic kv;
        keyT k;
        logic dt;
        int nextBefore;
        int landed;
        logic [15:0] lfsrSeq;
        modelPieceT fresh;
        rstReg = 1'b1;
        keyValid = 1'b0;
        key = keyIdle;
        dropTick = 1'b0;
        randState = 16'd52431;
        repeat (resetCycles) @(posedge clk_div);
        #1;
        rstReg = 1'b0;
        mArmed = 1'b1;
        mCmdValid = 1'b0;
        mCmd = moveDrop;
        mPiece = spawnPiece(3'd0);
        mNext = 3'd0;
        mLfsr = 16'hACE1;
        mObjects = '0;
        mLandings = 0;

        checkValue("objects", objects, '0);
        checkValue("nextBlock", nextBlock, '0);
        finishTest("reset");

        // Bar on row 6 stops at columns 0 to 3, then 6 to 9
        drops(4);
        press(keyLeft, 6);
        settle();
        checkValue("objects", objects, cellBits(20, 21, 22, 23));
        press(keyRight, 10);
        settle();
        checkValue("objects", objects, cellBits(26, 27, 28, 29));
        finishTest("walls");

        repeat (4) step(1'b1, keyLeft, 1'b0);
        step(1'b1, keyIdle, 1'b0);
        settle();
        checkValue("objects", objects, cellBits(25, 26, 27, 28));
        press(keyLeft, 1);
        settle();
        checkValue("objects", objects, cellBits(24, 25, 26, 27));
        finishTest("one press");

        repeat (4) begin
            press(keyRotate, 1);
            settle();
        end
        // Vertical bar at column 9 cannot turn flat
        press(keyRotate, 1);
        press(keyRight, 5);
        press(keyRotate, 1);
        settle();
        checkValue("objects", objects, cellBits(9, 19, 29, 39));
        finishTest("rotation");

        lfsrSeq = 16'hACE1;
        repeat (4) begin
            nextBefore = mNext;
            landed = mLandings;
            for (int i = 0; i < 30 && mLandings == landed; i++) drops(1);
            if (mLandings == landed) begin
                errorCount++;
                $display("Piece did not land within 30 drop ticks");
            end
            settle();
            lfsrSeq = galoisStep(lfsrSeq);
            checkValue("nextBlock", nextBlock, lfsrSeq % 5);
            // One drop was still in flight at landing
            drops(4);
            settle();
            fresh = spawnPiece(nextBefore);
            fresh.y = 5'd7;
            checkValue("objects", objects, renderPiece(fresh));
        end
        finishTest("landing");

        repeat (randomCycles) begin
            kv = randBits(1);
            k = keyT'(randBits(2));
            dt = (randBits(3) == 0);
            step(kv, k, dt);
        end
        finishTest("random");

        $display("Tests run: %0d, failed: %0d, checks: %0d, errors: %0d",
                 testsRun, failedTests, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/tetrisCore.sv */
`timescale 1ns/100ps
`default_nettype none

module tetrisCore import tetrisPkg::*; #(
    parameter lfsrT lfsrSeed = 16'hACE1
) (
    input  wire logic clk_div,
    input  wire logic rstReg,
    input  wire logic keyValid,
    input  wire keyT  key,
    input  wire logic dropTick,
    output boardT     objects,
    output blockT     nextBlock
);

    logic cmdValid;
    cmdT  cmd;

    pieceIf pieceBus ();

    // ########################################
    // Decode, move, render
    // ########################################
    keyDecode uKeyDecode (
        .clk_div  (clk_div),
        .rstReg   (rstReg),
        .keyValid (keyValid),
        .key      (key),
        .dropTick (dropTick),
        .cmdValid (cmdValid),
        .cmd      (cmd)
    );

    pieceMover #(
        .lfsrSeed (lfsrSeed)
    ) uPieceMover (
        .clk_div   (clk_div),
        .rstReg    (rstReg),
        .cmdValid  (cmdValid),
        .cmd       (cmd),
        .nextBlock (nextBlock),
        .piece     (pieceBus.mover)
    );

    boardRender uBoardRender (
        .clk_div (clk_div),
        .rstReg  (rstReg),
        .piece   (pieceBus.render),
        .objects (objects)
    );

endmodule

`default_nettype wire

/* design/boardRender.sv */
`timescale 1ns/100ps
`default_nettype none

module boardRender import tetrisPkg::*; (
    input  wire logic clk_div,
    input  wire logic rstReg,
    pieceIf.render    piece,
    output boardT     objects
);

    shapeT cells;
    boardT drawn;

    assign cells = shapeCells(piece.pieceType, piece.pieceRot);

    // Four piece cells onto the visible map
    always_comb begin
        int cellX;
        int cellY;
        drawn = '0;
        for (int i = 0; i < 4; i++) begin
            cellX = int'(piece.centerX) + $signed(cells[6*i +: 3]);
            cellY = int'(piece.centerY) + $signed(cells[6*i + 3 +: 3]);
            // Hidden spawn rows are not shown
            if (cellY >= hiddenRows && cellY < boardRows &&
                cellX >= 0 && cellX < boardCols) begin
                drawn[(cellY - hiddenRows) * boardCols + cellX] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_div) begin
        if (rstReg) begin
            objects <= '0;
        end else begin
            objects <= drawn;
        end
    end

    assert property (@(posedge clk_div) disable iff (rstReg)
        $countones(objects) <= 4)
        else $error("more than four cells set in objects");

endmodule

`default_nettype wire

/* design/pieceMover.sv */
`timescale 1ns/100ps
`default_nettype none

module pieceMover import tetrisPkg::*; #(
    parameter lfsrT lfsrSeed = 16'hACE1
) (
    input  wire logic clk_div,
    input  wire logic rstReg,
    input  wire logic cmdValid,
    input  wire cmdT  cmd,
    output blockT     nextBlock,
    pieceIf.mover     piece
);

    localparam lfsrT lfsrTaps = 16'hB400;

    lfsrT  lfsr;
    lfsrT  lfsrNext;
    rotT   candRot;
    int    candX;
    int    candY;
    shapeT candCells;
    logic  fits;
    logic  landing;

    // ########################################
    // Candidate position and bounds check
    // ########################################
    always_comb begin
        int cellX;
        int cellY;
        candX   = int'(piece.centerX);
        candY   = int'(piece.centerY);
        candRot = piece.pieceRot;
        case (cmd)
            cmdLeft:   candX = candX - 1;
            cmdRight:  candX = candX + 1;
            cmdRotate: candRot = piece.pieceRot + 2'd1;
            default:   candY = candY + 1;
        endcase
        candCells = shapeCells(piece.pieceType, candRot);
        fits      = 1'b1;
        for (int i = 0; i < 4; i++) begin
            cellX = candX + $signed(candCells[6*i +: 3]);
            cellY = candY + $signed(candCells[6*i + 3 +: 3]);
            if (cellX < 0 || cellX >= boardCols || cellY < 0 || cellY >= boardRows) begin
                fits = 1'b0;
            end
        end
    end

    // A drop that cannot move lands the piece
    assign landing = cmdValid && (cmd == cmdDrop) && !fits;

    // Right-shifting Galois step
    assign lfsrNext = (lfsr >> 1) ^ (lfsr[0] ? lfsrTaps : '0);

    // ########################################
    // Piece state, respawn and next block
    // ########################################
    always_ff @(posedge clk_div) begin
        if (rstReg) begin
            piece.pieceType <= '0;
            piece.pieceRot  <= '0;
            piece.centerX   <= colT'(spawnX);
            piece.centerY   <= rowT'(spawnY);
            nextBlock       <= '0;
            lfsr            <= lfsrSeed;
        end else if (landing) begin
            piece.pieceType <= nextBlock;
            piece.pieceRot  <= '0;
            piece.centerX   <= colT'(spawnX);
            piece.centerY   <= rowT'(spawnY);
            nextBlock       <= blockT'(lfsrNext % 16'd5);
            lfsr            <= lfsrNext;
        end else if (cmdValid && fits) begin
            piece.pieceRot <= candRot;
            piece.centerX  <= colT'(candX);
            piece.centerY  <= rowT'(candY);
        end
    end

    assert property (@(posedge clk_div) disable iff (rstReg)
        piece.centerX < boardCols)
        else $error("centerX left the board: %0d", piece.centerX);

    // Respawned type comes from nextBlock, so both stay in range
    assert property (@(posedge clk_div) disable iff (rstReg)
        piece.pieceType < 3'd5)
        else $error("pieceType undefined: %0d", piece.pieceType);

endmodule

`default_nettype wire

/* design/keyDecode.sv */
`timescale 1ns/100ps
`default_nettype none

module keyDecode import tetrisPkg::*; (
    input  wire logic clk_div,
    input  wire logic rstReg,
    input  wire logic keyValid,
    input  wire keyT  key,
    input  wire logic dropTick,
    output logic      cmdValid,
    output cmdT       cmd
);

    logic armed;
    logic keyAct;
    cmdT  keyCmd;

    // One action per press, an idle code re-arms
    assign keyAct = keyValid && (key != keyIdle) && armed;

    always_comb begin
        case (key)
            keyLeft:   keyCmd = cmdLeft;
            keyRight:  keyCmd = cmdRight;
            keyRotate: keyCmd = cmdRotate;
            // Idle never raises keyAct
            default:   keyCmd = cmdDrop;
        endcase
    end

    always_ff @(posedge clk_div) begin
        if (rstReg) begin
            armed    <= 1'b1;
            cmdValid <= 1'b0;
        end else begin
            if (keyValid) begin
                armed <= (key == keyIdle);
            end
            cmdValid <= dropTick || keyAct;
        end
    end

    // Drop wins over a coincident key action
    always_ff @(posedge clk_div) begin
        if (dropTick) begin
            cmd <= cmdDrop;
        end else if (keyAct) begin
            cmd <= keyCmd;
        end
    end

    assert property (@(posedge clk_div) disable iff (rstReg)
        cmdValid |-> !$isunknown(cmd))
        else $error("cmd undefined while cmdValid is high");

endmodule

`default_nettype wire

/* design/pieceIf.sv */
`timescale 1ns/100ps
`default_nettype none

// Live piece, always a placed in-bounds position
interface pieceIf import tetrisPkg::*; ();

    blockT pieceType;
    rotT   pieceRot;
    colT   centerX;
    rowT   centerY;

    modport mover (
        output pieceType,
        output pieceRot,
        output centerX,
        output centerY
    );

    modport render (
        input pieceType,
        input pieceRot,
        input centerX,
        input centerY
    );

endinterface

`default_nettype wire

/* design/tetrisPkg.sv */
`default_nettype none

package tetrisPkg;

    // ########################################
    // Board geometry
    // ########################################
    localparam int boardCols    = 10;
    localparam int boardRows    = 24;
    localparam int hiddenRows   = 4;
    localparam int visibleCells = (boardRows - hiddenRows) * boardCols;
    localparam int spawnX       = 5;
    localparam int spawnY       = 2;

    typedef logic [3:0]              colT;
    typedef logic [4:0]              rowT;
    typedef logic [2:0]              blockT;
    typedef logic [1:0]              rotT;
    typedef logic [1:0]              keyT;
    typedef logic [visibleCells-1:0] boardT;
    typedef logic [15:0]             lfsrT;
    // Four cells of {dy, dx}, signed 3-bit each, cell 0 in the low bits
    typedef logic [23:0]             shapeT;

    localparam keyT keyIdle   = 2'd0;
    localparam keyT keyLeft   = 2'd1;
    localparam keyT keyRight  = 2'd2;
    localparam keyT keyRotate = 2'd3;

    typedef enum logic [1:0] {cmdLeft, cmdRight, cmdRotate, cmdDrop} cmdT;

    // ########################################
    // Shape tables
    // ########################################
    // Tip cell of tee and ell, by rotation
    localparam int teeTipX [4] = '{0, 1, 0, -1};
    localparam int teeTipY [4] = '{-1, 0, 1, 0};
    localparam int ellTipX [4] = '{1, 1, -1, -1};
    localparam int ellTipY [4] = '{-1, 1, 1, -1};

    localparam int skewX [4][4] = '{'{-1, 0, 0, 1}, '{0, -1, -1, 0},
                                    '{0, 1, -1, 0}, '{0, -1, 0, -1}};
    localparam int skewY [4][4] = '{'{0, 0, -1, -1}, '{0, 0, -1, 1},
                                    '{0, 0, -1, -1}, '{0, 0, -1, 1}};

    function automatic shapeT shapeCells(input blockT blockType, input rotT rot);
        int dx [4];
        int dy [4];
        case (blockType)
            3'd1: begin
                dx = '{0, 1, 0, 1};
                dy = '{-1, -1, 0, 0};
            end
            3'd2, 3'd3: begin
                // Spine of three cells, tip depends on type and rotation
                if (rot[0]) begin
                    dx = '{0, 0, 0, 0};
                    dy = '{-1, 0, 1, 0};
                end else begin
                    dx = '{-1, 0, 1, 0};
                    dy = '{0, 0, 0, 0};
                end
                dx[3] = (blockType == 3'd2) ? teeTipX[rot] : ellTipX[rot];
                dy[3] = (blockType == 3'd2) ? teeTipY[rot] : ellTipY[rot];
            end
            3'd4: begin
                dx = skewX[rot];
                dy = skewY[rot];
            end
            default: begin
                // Bar
                if (rot[0]) begin
                    dx = '{0, 0, 0, 0};
                    dy = '{-2, -1, 0, 1};
                end else begin
                    dx = '{-2, -1, 0, 1};
                    dy = '{0, 0, 0, 0};
                end
            end
        endcase
        for (int i = 0; i < 4; i++) begin
            shapeCells[6*i +: 3]     = 3'(dx[i]);
            shapeCells[6*i + 3 +: 3] = 3'(dy[i]);
        end
    endfunction

endpackage

`default_nettype wire
